// File: source/window_pkg.sv
package window_pkg;

   // --------------------
   // sizes
   // --------------------
   // pixel and block geometry
   localparam int LEN_PIX = 8;
   localparam int LEN_BLK = 4;

   // one extra bank so that a block shifted by an offset still fits
   localparam int W_BANK = 2;
   localparam int N_BANK = LEN_BLK / W_BANK + 1;
   localparam int N_LANE = N_BANK * W_BANK;

   // window height and line length in blocks
   localparam int H_WIN = 3;
   localparam int LINE_BLOCKS = 4;

   // field widths
   localparam int W_COL = 2;
   localparam int W_OFFSET = 1;
   localparam int W_ROT = 2;
   localparam int W_ROW = $clog2(H_WIN);

   // --------------------
   // types
   // --------------------
   typedef logic [LEN_BLK-1:0][LEN_PIX-1:0] block_t;

   // one stored word, seen as banks for rotation or as lanes for offset
   typedef union packed {
      logic [N_BANK-1:0][W_BANK*LEN_PIX-1:0] banks;
      logic [N_LANE-1:0][LEN_PIX-1:0]        lanes;
   } bank_word_u;

   typedef struct packed {
      block_t                blk;
      logic [W_OFFSET-1:0]   offset;
      logic [W_ROT-1:0]      rot;
   } in_beat_t;

   typedef struct packed {
      bank_word_u            word;
      logic [N_BANK-1:0]     mask;
      logic [W_COL-1:0]      col;
      logic [W_OFFSET-1:0]   offset;
      logic [W_ROT-1:0]      rot;
      logic                  line_end;
      block_t                cur;
   } store_req_t;

   // one row entry of the line store
   typedef struct packed {
      bank_word_u            word;
      logic [W_OFFSET-1:0]   offset;
      logic [W_ROT-1:0]      rot;
   } entry_t;

   // index 0 is the older row
   typedef struct packed {
      entry_t [H_WIN-2:0]    old;
      block_t                cur;
   } fetch_t;

   // index 0 oldest line, index H_WIN-1 current line
   typedef struct packed {
      block_t [H_WIN-1:0]    row;
   } window_t;

endpackage

// File: source/block_packer.sv
`timescale 1ns/1ps

module block_packer
   import window_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_valid,
   output logic       in_ready,
   input  in_beat_t   in_beat,
   output logic       req_valid,
   input  logic       req_ready,
   output store_req_t req
);

   logic              take;
   logic [W_COL-1:0]  col;
   logic              last_col;
   bank_word_u        placed;
   bank_word_u        rotated;
   logic [N_LANE-1:0] lane_mask;
   logic [N_BANK-1:0] bank_hit;
   logic [N_BANK-1:0] bank_mask;

   // slot frees up when downstream takes the current request
   assign in_ready = !req_valid || req_ready;
   assign take = in_valid && in_ready;
   assign last_col = (col == W_COL'(LINE_BLOCKS - 1));

   // --------------------
   // offset then rotate
   // --------------------
   always_comb begin
      placed = '0;
      lane_mask = '0;
      for (int l = 0; l < LEN_BLK; l++) begin
         placed.lanes[l + int'(in_beat.offset)] = in_beat.blk[l];
         lane_mask[l + int'(in_beat.offset)] = 1'b1;
      end

      // a bank is touched if any block lane lands in it
      for (int b = 0; b < N_BANK; b++) begin
         bank_hit[b] = |lane_mask[b*W_BANK +: W_BANK];
      end

      rotated = '0;
      bank_mask = '0;
      for (int b = 0; b < N_BANK; b++) begin
         rotated.banks[(b + int'(in_beat.rot)) % N_BANK] = placed.banks[b];
         bank_mask[(b + int'(in_beat.rot)) % N_BANK] = bank_hit[b];
      end
   end

   // --------------------
   // control
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_valid <= 1'b0;
         col <= '0;
      end else if (take) begin
         req_valid <= 1'b1;
         col <= last_col ? '0 : col + 1'b1;
      end else if (req_ready) begin
         req_valid <= 1'b0;
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      if (take) begin
         req.word <= rotated;
         req.mask <= bank_mask;
         req.col <= col;
         req.offset <= in_beat.offset;
         req.rot <= in_beat.rot;
         req.line_end <= last_col;
         req.cur <= in_beat.blk;
      end
   end

   // rotation beyond the last bank would alias onto another bank
   a_rot_range: assert property (@(posedge clk) disable iff (!rst_n)
      take |-> (int'(in_beat.rot) < N_BANK));

endmodule

// File: source/line_store.sv
`timescale 1ns/1ps

module line_store
   import window_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       req_valid,
   output logic       req_ready,
   input  store_req_t req,
   output logic       fetch_valid,
   input  logic       fetch_ready,
   output fetch_t     fetch
);

   logic             take;
   logic [H_WIN-1:0] wr_row;
   logic [W_ROW-1:0] wr_idx;
   logic [W_ROW-1:0] prev1_idx;
   logic [W_ROW-1:0] prev2_idx;

   // row entries, cleared so the first lines read back as zero
   entry_t           mem [H_WIN][LINE_BLOCKS];

   assign req_ready = !fetch_valid || fetch_ready;
   assign take = req_valid && req_ready;

   // --------------------
   // row selection
   // --------------------
   always_comb begin
      wr_idx = '0;
      for (int r = 0; r < H_WIN; r++) begin
         if (wr_row[r]) begin
            wr_idx = W_ROW'(r);
         end
      end
   end

   // rows written one and two lines earlier
   assign prev1_idx = (wr_idx == '0) ? W_ROW'(H_WIN - 1) : wr_idx - 1'b1;
   assign prev2_idx = (prev1_idx == '0) ? W_ROW'(H_WIN - 1) : prev1_idx - 1'b1;

   // write row moves on after the last block of a line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_row <= H_WIN'(1);
      end else if (take && req.line_end) begin
         wr_row <= {wr_row[H_WIN-2:0], wr_row[H_WIN-1]};
      end
   end

   // --------------------
   // masked write
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < H_WIN; r++) begin
            for (int c = 0; c < LINE_BLOCKS; c++) begin
               mem[r][c] <= '0;
            end
         end
      end else if (take) begin
         // banks outside the mask keep their old content
         for (int b = 0; b < N_BANK; b++) begin
            if (req.mask[b]) begin
               mem[wr_idx][req.col].word.banks[b] <= req.word.banks[b];
            end
         end
         mem[wr_idx][req.col].offset <= req.offset;
         mem[wr_idx][req.col].rot <= req.rot;
      end
   end

   // --------------------
   // read slot
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_valid <= 1'b0;
      end else if (take) begin
         fetch_valid <= 1'b1;
      end else if (fetch_ready) begin
         fetch_valid <= 1'b0;
      end
   end

   // older row first
   always_ff @(posedge clk) begin
      if (take) begin
         fetch.old[0] <= mem[prev2_idx][req.col];
         fetch.old[1] <= mem[prev1_idx][req.col];
         fetch.cur <= req.cur;
      end
   end

   a_row_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot(wr_row));

   a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch));

endmodule

// File: source/window_assembler.sv
`timescale 1ns/1ps

module window_assembler
   import window_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    fetch_valid,
   output logic    fetch_ready,
   input  fetch_t  fetch,
   output logic    out_valid,
   input  logic    out_ready,
   output window_t out_window
);

   logic       take;
   bank_word_u unrot [H_WIN-1];
   block_t     decoded [H_WIN-1];

   assign fetch_ready = !out_valid || out_ready;
   assign take = fetch_valid && fetch_ready;

   // --------------------
   // decode older rows
   // --------------------
   // undo the bank rotation first, then pick lanes from the offset
   always_comb begin
      for (int r = 0; r < H_WIN - 1; r++) begin
         for (int b = 0; b < N_BANK; b++) begin
            unrot[r].banks[b] =
               fetch.old[r].word.banks[(b + int'(fetch.old[r].rot)) % N_BANK];
         end
         for (int l = 0; l < LEN_BLK; l++) begin
            decoded[r][l] = unrot[r].lanes[l + int'(fetch.old[r].offset)];
         end
      end
   end

   // --------------------
   // output slot
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         for (int r = 0; r < H_WIN - 1; r++) begin
            out_window.row[r] <= decoded[r];
         end
         // current block sits on top of the window
         out_window.row[H_WIN-1] <= fetch.cur;
      end
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_window));

endmodule

// File: source/line_window_top.sv
`timescale 1ns/1ps

module line_window_top
   import window_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  in_beat_t in_beat,
   output logic     out_valid,
   input  logic     out_ready,
   output window_t  out_window
);

   // packer to store
   logic       req_valid;
   logic       req_ready;
   store_req_t req;

   // store to assembler
   logic       fetch_valid;
   logic       fetch_ready;
   fetch_t     fetch;

   block_packer u_block_packer (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_beat   (in_beat),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req)
   );

   line_store u_line_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req         (req),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch       (fetch)
   );

   window_assembler u_window_assembler (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch       (fetch),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_window  (out_window)
   );

endmodule

// File: test/tb_line_window.sv
`timescale 1ns/1ps

module tb_line_window
   import window_pkg::*;
();

   localparam int N_BEATS = 40;
   localparam int N_FIELDS = 6;
   localparam int CLK_PERIOD = 8;
   localparam int WATCHDOG_NS = N_BEATS * 20 * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic        in_ready;
   in_beat_t    in_beat;
   logic        out_valid;
   logic        out_ready;
   window_t     out_window;

   // block, offset, rotate and three expected rows per beat
   logic [31:0] vec_mem [N_BEATS*N_FIELDS];

   int unsigned lcg_state;
   int          seen;
   logic        held;
   window_t     held_window;
   window_t     exp_window;

   line_window_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_beat    (in_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_window (out_window)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // --------------------
   // helpers
   // --------------------
   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // expected window for one beat with the oldest line at index 0
   function automatic window_t expected_window(input int idx);
      window_t w;
      for (int r = 0; r < H_WIN; r++) begin
         w.row[r] = vec_mem[idx*N_FIELDS + 3 + r];
      end
      return w;
   endfunction

   task automatic stop_with_failure();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // hold one beat until the packer takes it
   task automatic send_beat(input int idx);
      in_valid = 1'b1;
      in_beat.blk = vec_mem[idx*N_FIELDS];
      in_beat.offset = vec_mem[idx*N_FIELDS + 1][W_OFFSET-1:0];
      in_beat.rot = vec_mem[idx*N_FIELDS + 2][W_ROT-1:0];
      @(negedge clk);
      while (!in_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      in_valid = 1'b0;
      repeat (n) @(posedge clk);
      #1;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      out_ready = 1'b0;
      lcg_state = 43;
      seen = 0;
      held = 1'b0;
      held_window = '0;

      $readmemh("test/line_window_vectors.txt", vec_mem);
      assert (!$isunknown(vec_mem[N_BEATS*N_FIELDS-1])) else begin
         $display("vector file test/line_window_vectors.txt is missing or too short");
         stop_with_failure();
      end

      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      @(negedge clk);
      assert (in_ready && !out_valid) else begin
         $display("CHECK FAILED time=%0t in_ready %b out_valid %b after reset",
                  $time, in_ready, out_valid);
         stop_with_failure();
      end
      @(posedge clk);
      #1;

      // gaps on the input side now and then
      for (int i = 0; i < N_BEATS; i++) begin
         if (i % 7 == 5) begin
            idle_cycles(1 + i % 3);
         end
         send_beat(i);
      end

      wait (seen == N_BEATS);
      repeat (4) @(negedge clk);
      assert (!out_valid) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("CHECK FAILED time=%0t out_valid still high after %0d windows",
                  $time, seen);
         stop_with_failure();
      end
   end

   // random back-pressure on the output
   initial begin
      @(posedge rst_n);
      forever begin
         @(posedge clk);
         #1;
         out_ready = (next_rand() % 10) < 7;
      end
   end

   // --------------------
   // output monitor
   // --------------------
   // outputs and out_ready sampled on the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (held) begin
            assert (out_valid && out_window == held_window) else begin
               $display("CHECK FAILED time=%0t window %0d changed while stalled",
                        $time, seen);
               stop_with_failure();
            end
         end
         held = out_valid && !out_ready;
         held_window = out_window;

         if (out_valid && out_ready) begin
            assert (seen < N_BEATS) else begin
               $display("more windows arrived than beats were sent");
               stop_with_failure();
            end
            exp_window = expected_window(seen);
            assert (out_window == exp_window) else begin
               $display("CHECK FAILED time=%0t window %0d: got %h %h %h, expected %h %h %h",
                        $time, seen,
                        out_window.row[0], out_window.row[1], out_window.row[2],
                        exp_window.row[0], exp_window.row[1], exp_window.row[2]);
               stop_with_failure();
            end
            seen++;
         end
      end
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: outputs stopped arriving after %0d of %0d windows", seen, N_BEATS);
      stop_with_failure();
   end

endmodule

// File: test/line_window_vectors.txt
// one input block per line, all values in hex
// block offset rotate expected_oldest expected_previous expected_current
// line 0
03020100 0 0 00000000 00000000 03020100
07060504 1 2 00000000 00000000 07060504
0b0a0908 0 1 00000000 00000000 0b0a0908
0f0e0d0c 1 0 00000000 00000000 0f0e0d0c
// line 1
13121110 1 1 00000000 03020100 13121110
17161514 0 0 00000000 07060504 17161514
1b1a1918 1 2 00000000 0b0a0908 1b1a1918
1f1e1d1c 0 1 00000000 0f0e0d0c 1f1e1d1c
// line 2
23222120 0 2 03020100 13121110 23222120
27262524 1 1 07060504 17161514 27262524
2b2a2928 0 0 0b0a0908 1b1a1918 2b2a2928
2f2e2d2c 1 2 0f0e0d0c 1f1e1d1c 2f2e2d2c
// line 3
33323130 1 0 13121110 23222120 33323130
37363534 0 2 17161514 27262524 37363534
3b3a3938 1 1 1b1a1918 2b2a2928 3b3a3938
3f3e3d3c 0 0 1f1e1d1c 2f2e2d2c 3f3e3d3c
// line 4
43424140 0 1 23222120 33323130 43424140
47464544 1 0 27262524 37363534 47464544
4b4a4948 0 2 2b2a2928 3b3a3938 4b4a4948
4f4e4d4c 1 1 2f2e2d2c 3f3e3d3c 4f4e4d4c
// line 5
53525150 1 2 33323130 43424140 53525150
57565554 0 1 37363534 47464544 57565554
5b5a5958 1 0 3b3a3938 4b4a4948 5b5a5958
5f5e5d5c 0 2 3f3e3d3c 4f4e4d4c 5f5e5d5c
// line 6
63626160 0 0 43424140 53525150 63626160
67666564 1 2 47464544 57565554 67666564
6b6a6968 0 1 4b4a4948 5b5a5958 6b6a6968
6f6e6d6c 1 0 4f4e4d4c 5f5e5d5c 6f6e6d6c
// line 7
73727170 1 1 53525150 63626160 73727170
77767574 0 0 57565554 67666564 77767574
7b7a7978 1 2 5b5a5958 6b6a6968 7b7a7978
7f7e7d7c 0 1 5f5e5d5c 6f6e6d6c 7f7e7d7c
// line 8
83828180 0 2 63626160 73727170 83828180
87868584 1 1 67666564 77767574 87868584
8b8a8988 0 0 6b6a6968 7b7a7978 8b8a8988
8f8e8d8c 1 2 6f6e6d6c 7f7e7d7c 8f8e8d8c
// line 9
93929190 1 0 73727170 83828180 93929190
97969594 0 2 77767574 87868584 97969594
9b9a9998 1 1 7b7a7978 8b8a8988 9b9a9998
9f9e9d9c 0 0 7f7e7d7c 8f8e8d8c 9f9e9d9c

// File: sim.f
source/window_pkg.sv
source/block_packer.sv
source/line_store.sv
source/window_assembler.sv
source/line_window_top.sv
test/tb_line_window.sv
